// ==== all.f ====
+incdir+.
mipsPkg.sv
aluDecoder.sv
controller.sv
regFile.sv
datapath.sv
memory.sv
mipsMulticycle.sv
mips_sva.sv
tb_mips.sv

// ==== aluDecoder.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module aluDecoder (
	input  mipsPkg::funct_t      funct,
	input  mipsPkg::aluOp_t      aluOp,
	output mipsPkg::aluControl_t aluControl
);
	import mipsPkg::*;

	always_comb begin
		case (aluOp)
			`ALUOP_ADD: aluControl = aluAdd; // address and PC arithmetic
			`ALUOP_SUB: aluControl = aluSub; // beq compare
			default: begin // R-type decodes funct
				case (funct)
					`FUNCT_ADD: aluControl = aluAdd;
					`FUNCT_SUB: aluControl = aluSub;
					`FUNCT_AND: aluControl = aluAnd;
					`FUNCT_OR:  aluControl = aluOr;
					`FUNCT_SLT: aluControl = aluSlt;
					default:    aluControl = aluAdd; // unknown funct
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== controller.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module controller (
	input  logic                  clk,
	input  logic                  reset,
	input  mipsPkg::opcode_t      opcode,
	input  mipsPkg::funct_t       funct,
	output mipsPkg::ctrlSignals_t ctrl,
	output mipsPkg::aluControl_t  aluControl,
	output logic                  halted
);
	import mipsPkg::*;

	ctrlState_t state;
	ctrlState_t nextState;

	aluDecoder aluDec (
		.funct     (funct),
		.aluOp     (ctrl.aluOp),
		.aluControl(aluControl)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (opcode)
					`OP_LW,
					`OP_SW:    nextState = memAdr;
					`OP_RTYPE: nextState = execute;
					`OP_BEQ:   nextState = branch;
					`OP_ADDI:  nextState = addiExecute;
					default:   nextState = halt; // unsupported opcode stops the core
				endcase
			end
			memAdr: begin
				if (opcode == `OP_LW) begin
					nextState = memRead;
				end else begin
					nextState = memWrite; // only sw gets here otherwise
				end
			end
			memRead:       nextState = memWriteback;
			memWriteback:  nextState = fetch;
			memWrite:      nextState = fetch;
			execute:       nextState = aluWriteback;
			aluWriteback:  nextState = fetch;
			branch:        nextState = fetch;
			addiExecute:   nextState = addiWriteback;
			addiWriteback: nextState = fetch;
			halt:          nextState = halt; // left only through reset
			default:       nextState = fetch;
		endcase
	end

	// Moore outputs default to inactive in every state
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = `ALUOP_ADD;
		case (state)
			fetch: begin
				ctrl.aluSrcB = 2'b01; // PC + 4
				ctrl.irWrite = 1'b1;
				ctrl.pcWrite = 1'b1;
			end
			decode: begin
				ctrl.aluSrcB = 2'b11; // branch target into ALU-out
			end
			memAdr: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
			end
			memRead: begin
				ctrl.iOrD = 1'b1;
			end
			memWriteback: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1; // rt <= loaded word
			end
			memWrite: begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			execute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = `ALUOP_FUNCT;
			end
			aluWriteback: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			branch: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = `ALUOP_SUB; // zero when A == B
				ctrl.pcSrc = 1'b1;
				ctrl.branch = 1'b1;
			end
			addiExecute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
			end
			addiWriteback: begin
				ctrl.regWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign halted = (state == halt);

endmodule

`default_nettype wire

// ==== datapath.sv ====
`default_nettype none
`timescale 1ns/1ps

module datapath (
	input  logic                  clk,
	input  logic                  reset,
	input  mipsPkg::ctrlSignals_t ctrl,
	input  mipsPkg::aluControl_t  aluControl,
	input  mipsPkg::word_t        readData,
	output mipsPkg::word_t        memAddr,
	output mipsPkg::word_t        writeData,
	output mipsPkg::opcode_t      opcode,
	output mipsPkg::funct_t       funct,
	output mipsPkg::regAddr_t     regWriteAddr,
	output mipsPkg::word_t        regWriteData
);
	import mipsPkg::*;

	word_t pc;
	word_t instr;
	word_t dataReg;
	word_t aReg;
	word_t bReg;
	word_t aluOut;
	word_t rd1;
	word_t rd2;
	word_t signImm;
	word_t srcA;
	word_t srcB;
	word_t aluResult;
	word_t pcNext;
	logic zero;
	logic pcEn;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign signImm = {{16{instr[15]}}, instr[15:0]};

	assign regWriteAddr = ctrl.regDst ? instr[15:11] : instr[20:16]; // rd or rt
	assign regWriteData = ctrl.memToReg ? dataReg : aluOut;

	regFile rf (
		.clk        (clk),
		.readAddr1  (instr[25:21]),
		.readAddr2  (instr[20:16]),
		.writeAddr  (regWriteAddr),
		.writeEnable(ctrl.regWrite),
		.writeData  (regWriteData),
		.readData1  (rd1),
		.readData2  (rd2)
	);

	assign srcA = ctrl.aluSrcA ? aReg : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			2'b00:   srcB = bReg;
			2'b01:   srcB = 32'd4;
			2'b10:   srcB = signImm;
			default: srcB = {signImm[29:0], 2'b00}; // word offset to bytes
		endcase
	end

	always_comb begin
		aluResult = '0;
		case (aluControl)
			aluAnd:  aluResult = srcA & srcB;
			aluOr:   aluResult = srcA | srcB;
			aluAdd:  aluResult = srcA + srcB;
			aluSub:  aluResult = srcA - srcB;
			aluSlt:  aluResult[0] = $signed(srcA) < $signed(srcB);
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0);

	// taken beq loads the target computed during decode
	assign pcEn = ctrl.pcWrite | (ctrl.branch & zero);
	assign pcNext = ctrl.pcSrc ? aluOut : aluResult;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.irWrite) begin
			instr <= readData;
		end
		dataReg <= readData;
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
	end

	assign memAddr = ctrl.iOrD ? aluOut : pc;
	assign writeData = bReg;

endmodule

`default_nettype wire

// ==== memory.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module memory (
	input  logic           clk,
	input  mipsPkg::word_t addr,
	input  logic           writeEnable,
	input  mipsPkg::word_t writeData,
	output mipsPkg::word_t readData,
	input  logic           loadEn,
	input  mipsPkg::word_t loadAddr,
	input  mipsPkg::word_t loadData
);
	import mipsPkg::*;

	localparam int IdxBits = $clog2(`MEM_DEPTH);

	word_t mem [`MEM_DEPTH];
	logic [IdxBits-1:0] idx;
	logic [IdxBits-1:0] loadIdx;

	assign idx = addr[IdxBits+1:2]; // byte address to word index
	assign loadIdx = loadAddr[IdxBits+1:2];

	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadIdx] <= loadData; // program load while in reset
		end else if (writeEnable) begin
			mem[idx] <= writeData;
		end
	end

	assign readData = mem[idx];

endmodule

`default_nettype wire

// ==== mipsMulticycle.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module mipsMulticycle (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 loadEn,
	input  mipsPkg::word_t       loadAddr,
	input  mipsPkg::word_t       loadData,
	output mipsPkg::writeEvent_t writeEvent,
	output logic                 halted
);
	import mipsPkg::*;

	ctrlSignals_t ctrl;
	aluControl_t aluControl;
	opcode_t opcode;
	funct_t funct;
	word_t memAddr;
	word_t memWData;
	word_t memRData;
	regAddr_t regWriteAddr;
	word_t regWriteData;

	controller ctrlUnit (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.funct     (funct),
		.ctrl      (ctrl),
		.aluControl(aluControl),
		.halted    (halted)
	);

	datapath dp (
		.clk         (clk),
		.reset       (reset),
		.ctrl        (ctrl),
		.aluControl  (aluControl),
		.readData    (memRData),
		.memAddr     (memAddr),
		.writeData   (memWData),
		.opcode      (opcode),
		.funct       (funct),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData)
	);

	memory mem (
		.clk        (clk),
		.addr       (memAddr),
		.writeEnable(ctrl.memWrite),
		.writeData  (memWData),
		.readData   (memRData),
		.loadEn     (loadEn),
		.loadAddr   (loadAddr),
		.loadData   (loadData)
	);

	// valid during the state whose closing edge commits the write
	always_comb begin
		writeEvent = '0;
		if (ctrl.regWrite) begin
			writeEvent.valid = 1'b1;
			writeEvent.addr = {{(`DATA_WIDTH-`REG_ADDR_WIDTH){1'b0}}, regWriteAddr};
			writeEvent.data = regWriteData;
		end else if (ctrl.memWrite) begin
			writeEvent.valid = 1'b1;
			writeEvent.isMem = 1'b1;
			writeEvent.addr = memAddr;
			writeEvent.data = memWData;
		end
	end

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none
`include "mips_settings.svh"

package mipsPkg;
	typedef logic [`DATA_WIDTH-1:0] word_t; // data word or byte address
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [1:0] aluOp_t; // add, subtract or decode funct

	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluControl_t;

	typedef enum logic [3:0] {
		fetch         = 4'd0,
		decode        = 4'd1,
		memAdr        = 4'd2,
		memRead       = 4'd3,
		memWriteback  = 4'd4,
		memWrite      = 4'd5,
		execute       = 4'd6,
		aluWriteback  = 4'd7,
		branch        = 4'd8,
		addiExecute   = 4'd9,
		addiWriteback = 4'd10,
		halt          = 4'd11
	} ctrlState_t;

	typedef struct packed {
		logic memToReg; // register write data from data register
		logic regDst; // rd instead of rt
		logic iOrD; // memory address from ALU-out
		logic pcSrc; // next PC from ALU-out
		logic aluSrcA; // A register instead of PC
		logic [1:0] aluSrcB; // B, 4, imm, imm << 2
		logic irWrite;
		logic memWrite;
		logic pcWrite;
		logic branch;
		logic regWrite;
		aluOp_t aluOp;
	} ctrlSignals_t;

	typedef struct packed {
		logic valid;
		logic isMem; // memory write, else register write
		word_t addr; // register number on register writes
		word_t data;
	} writeEvent_t;
endpackage

`default_nettype wire

// ==== mips_input.txt ====
// word 0 program length, then the program words, then the event count
// events are isMem (1 for memory write), address (register number for register writes), data
13
20010005 // addi $1, $0, 5
2002FFFD // addi $2, $0, -3
00221820 // add  $3, $1, $2
00222022 // sub  $4, $1, $2
00222824 // and  $5, $1, $2
00223025 // or   $6, $1, $2
0041382A // slt  $7, $2, $1
0022402A // slt  $8, $1, $2
200900C0 // addi $9, $0, 0xc0
AD240004 // sw   $4, 4($9)
8D2A0004 // lw   $10, 4($9)
11440002 // beq  $10, $4, +2 taken
200B0001 // addi $11, $0, 1 skipped
200C0002 // addi $12, $0, 2 skipped
10220001 // beq  $1, $2, +1 not taken
20000007 // addi $0, $0, 7
00016820 // add  $13, $0, $1
FC000000 // unsupported opcode, halts
200E0009 // addi $14, $0, 9 never reached
0D
0 00000001 00000005
0 00000002 FFFFFFFD
0 00000003 00000002
0 00000004 00000008
0 00000005 00000005
0 00000006 FFFFFFFD
0 00000007 00000001
0 00000008 00000000
0 00000009 000000C0
1 000000C4 00000008
0 0000000A 00000008
0 00000000 00000007
0 0000000D 00000005

// ==== mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define MEM_DEPTH       64 // words

`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_RTYPE  6'b000000
`define OP_BEQ    6'b000100
`define OP_ADDI   6'b001000

`define FUNCT_ADD 6'b100000
`define FUNCT_SUB 6'b100010
`define FUNCT_AND 6'b100100
`define FUNCT_OR  6'b100101
`define FUNCT_SLT 6'b101010

// operation class from the controller to the ALU decoder
`define ALUOP_ADD   2'b00
`define ALUOP_SUB   2'b01
`define ALUOP_FUNCT 2'b10

`endif

// ==== mips_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module controllerChecks (
	input logic                  clk,
	input logic                  reset,
	input mipsPkg::ctrlState_t   state,
	input mipsPkg::ctrlSignals_t ctrl,
	input logic                  halted
);
	import mipsPkg::*;

	legalState: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(state) && (state <= halt))
		else $error("controller state has an illegal encoding");

	// every closing state of an instruction returns to fetch
	backToFetch: assert property (@(posedge clk) disable iff (reset)
		(state inside {memWriteback, memWrite, aluWriteback, branch, addiWriteback})
		|=> (state == fetch))
		else $error("closing state not followed by fetch");

	haltSticks: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else $error("controller left halt without reset");

	oneWriteKind: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.regWrite && ctrl.memWrite))
		else $error("register write and memory write in the same state");

endmodule

bind controller controllerChecks checks (
	.clk   (clk),
	.reset (reset),
	.state (state),
	.ctrl  (ctrl),
	.halted(halted)
);

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module regFile (
	input  logic              clk,
	input  mipsPkg::regAddr_t readAddr1,
	input  mipsPkg::regAddr_t readAddr2,
	input  mipsPkg::regAddr_t writeAddr,
	input  logic              writeEnable,
	input  mipsPkg::word_t    writeData,
	output mipsPkg::word_t    readData1,
	output mipsPkg::word_t    readData2
);
	import mipsPkg::*;

	word_t regs [2**`REG_ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (writeEnable && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData; // $zero is never stored
		end
	end

	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the MIPS multicycle testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mips -f all.f -o tb_mips
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_mips > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^test passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_mips.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_mips;
	import mipsPkg::*;

	localparam int PrologueRegs = 8; // random values for $16..$23
	localparam int FirstRandReg = 16;
	localparam int WaitLimit = 50; // cycles per wait

	logic clk;
	logic reset;
	logic loadEn;
	word_t loadAddr;
	word_t loadData;
	writeEvent_t writeEvent;
	logic halted;

	word_t fileWords [0:255];
	word_t progWords [$];
	writeEvent_t expected [$];

	mipsMulticycle DUT (
		.clk       (clk),
		.reset     (reset),
		.loadEn    (loadEn),
		.loadAddr  (loadAddr),
		.loadData  (loadData),
		.writeEvent(writeEvent),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic checkValue(input string what, input word_t actual, input word_t want);
		if (actual !== want) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, actual, want);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s at %0t ns", reason, $time);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	// addi $r, $0, imm with a random signed value for each seeded register
	task automatic buildPrologue();
		int value;
		writeEvent_t ev;
		for (int r = 0; r < PrologueRegs; r++) begin
			value = int'($urandom_range(65535)) - 32768; // any 16-bit signed immediate
			progWords.push_back({`OP_ADDI, 5'd0, 5'(FirstRandReg + r), value[15:0]});
			ev = '0;
			ev.valid = 1'b1;
			ev.addr = 32'(FirstRandReg + r);
			ev.data = value; // $0 + value
			expected.push_back(ev);
		end
	endtask

	task automatic readInputFile();
		logic [7:0] pos;
		int count;
		writeEvent_t ev;
		$readmemh("mips_input.txt", fileWords);
		count = fileWords[0];
		pos = 8'd1;
		repeat (count) begin
			progWords.push_back(fileWords[pos]);
			pos = pos + 8'd1;
		end
		count = fileWords[pos];
		pos = pos + 8'd1;
		repeat (count) begin
			ev = '0;
			ev.valid = 1'b1;
			ev.isMem = fileWords[pos][0];
			ev.addr = fileWords[pos + 8'd1];
			ev.data = fileWords[pos + 8'd2];
			expected.push_back(ev);
			pos = pos + 8'd3;
		end
	endtask

	// enter on a falling edge and return on the falling edge inside the event state
	task automatic waitForEvent();
		int cycles;
		cycles = 0;
		while (!writeEvent.valid) begin
			if (halted) begin
				abortRun("core halted before all expected writes appeared");
			end else if (cycles == WaitLimit) begin
				abortRun("timed out waiting for the next write event");
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	initial begin
		int cycles;
		reset = 1'b1;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		void'($urandom(32'h967b));
		buildPrologue();
		readInputFile();
		if (progWords.size() <= PrologueRegs) begin
			abortRun("no program words could be read from mips_input.txt");
		end

		foreach (progWords[i]) begin
			@(negedge clk);
			loadEn = 1'b1;
			loadAddr = 32'(i) << 2; // word i at byte address 4*i
			loadData = progWords[i];
		end
		@(negedge clk);
		loadEn = 1'b0;
		repeat (10) @(negedge clk); // reset stays high 10 cycles past the load
		reset = 1'b0;

		foreach (expected[n]) begin
			waitForEvent();
			checkValue($sformatf("event %0d memory flag", n), {31'd0, writeEvent.isMem},
				{31'd0, expected[n].isMem});
			checkValue($sformatf("event %0d address", n), writeEvent.addr, expected[n].addr);
			checkValue($sformatf("event %0d data", n), writeEvent.data, expected[n].data);
			@(negedge clk); // leave this event's state
		end

		cycles = 0;
		while (!halted) begin
			if (writeEvent.valid) begin
				abortRun("write event seen after the last expected one");
			end else if (cycles == WaitLimit) begin
				abortRun("timed out waiting for halted");
			end
			@(negedge clk);
			cycles++;
		end

		// halt holds and nothing more is written
		repeat (20) begin
			@(negedge clk);
			checkValue("halted", {31'd0, halted}, 32'd1);
			checkValue("event valid after halt", {31'd0, writeEvent.valid}, 32'd0);
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire
